/* compile.f */
+incdir+src
src/note_pkg.sv
src/audio_pkg.sv
src/note_recognizer.sv
src/segment_note_decoder.sv
src/note_synthesizer.sv
src/note_relay_top.sv
bench/note_relay_properties.sv
bench/note_relay_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the note relay testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module note_relay_tb -f compile.f -o note_relay_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/note_relay_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "PASS"
exit 0

/* bench/note_relay_tb.sv */
`timescale 1ns/1ps
`include "note_defines.svh"

module note_relay_tb;

    import note_pkg::*;
    import audio_pkg::*;

    localparam int            MAX_ENTRIES = 16;
    localparam sound_sample_t LEVEL_HIGH  = sound_sample_t'(`TONE_AMPL);
    localparam sound_sample_t LEVEL_LOW   = -LEVEL_HIGH;

    logic                  clk;
    logic                  rst;
    mic_sample_t           mic;
    seg_t                  abcdefgh;
    logic [`W_DIGIT - 1:0] digit;
    sound_sample_t         sound;

    int    seed = 32'h40131f02;

    // Stimulus table
    string test_name   [MAX_ENTRIES];
    int    tone_period [MAX_ENTRIES];  // Cycles per period
    int    tone_count  [MAX_ENTRIES];  // Periods to play
    logic  hold_note   [MAX_ENTRIES];  // Display and tone must stay as they are
    seg_t  exp_seg     [MAX_ENTRIES];
    logic  tone_check  [MAX_ENTRIES];
    int    n_entries;

    seg_t  shown_seg;                  // Pattern shown before the entry
    int    shown_half;                 // Half period of the tone being played
    logic  reached;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    note_relay_top uut (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .mic      ( mic      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .sound    ( sound    )
    );

    // --------------------
    // Reporting and compares

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        abort_run();
    endtask

    task automatic check_segments(input string name, input seg_t expected, input seg_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected segments %h, got %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_sound(input string name, input sound_sample_t expected,
                               input sound_sample_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected sound %0d, got %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_digit(input string name, input logic [`W_DIGIT - 1:0] expected,
                               input logic [`W_DIGIT - 1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected digit %b, got %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_period(input string name, input period_t expected, input period_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected tone period %0d, got %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // --------------------
    // Table

    task automatic add_entry(input string name, input int period, input int count,
                             input logic hold, input seg_t seg, input logic tone);
        test_name[n_entries]   = name;
        tone_period[n_entries] = period;
        tone_count[n_entries]  = count;
        hold_note[n_entries]   = hold;
        exp_seg[n_entries]     = seg;
        tone_check[n_entries]  = tone;
        n_entries++;
    endtask

    task automatic build_table();
        n_entries = 0;
        //         name              period count hold  pattern tone check
        add_entry("note_c_sharp",    3608,  4,    1'b0, 8'h9D,  1'b1);
        add_entry("note_d",          3405,  4,    1'b0, 8'h7A,  1'b1);
        add_entry("note_d_sharp",    3214,  4,    1'b0, 8'h7B,  1'b1);
        add_entry("note_e",          3034,  4,    1'b0, 8'h9E,  1'b1);
        add_entry("note_f",          2863,  4,    1'b0, 8'h8E,  1'b1);
        add_entry("note_f_sharp",    2703,  4,    1'b0, 8'h8F,  1'b1);
        add_entry("note_g",          2551,  4,    1'b0, 8'hBC,  1'b1);
        add_entry("note_g_sharp",    2408,  4,    1'b0, 8'hBD,  1'b1);
        add_entry("note_a",          2273,  4,    1'b0, 8'hEE,  1'b1);
        add_entry("note_a_sharp",    2145,  4,    1'b0, 8'hEF,  1'b1);
        add_entry("note_b",          2025,  4,    1'b0, 8'h3E,  1'b1);
        add_entry("note_c",          3822,  4,    1'b0, 8'h9C,  1'b1);
        add_entry("debounce_glitch", 2025,  1,    1'b1, 8'h00,  1'b0);  // One B period
        add_entry("debounce_resume", 3822,  4,    1'b0, 8'h9C,  1'b1);
        add_entry("note_g_again",    2551,  4,    1'b0, 8'hBC,  1'b1);  // Not the reset note
        add_entry("out_of_range",    7644,  2,    1'b1, 8'h00,  1'b1);  // Twice the C period
    endtask

    // --------------------
    // Stimulus and monitors

    // Positive first half, negative second half, random magnitudes
    task automatic play_tone(input int period, input int count);
        logic [31:0] rnd;
        mic_sample_t high;
        mic_sample_t low;
        for (int k = 0; k < count; k++) begin
            rnd  = $random(seed);
            high = mic_sample_t'({1'b0, rnd[22:0]});
            rnd  = $random(seed);
            low  = mic_sample_t'({1'b1, rnd[22:0]});
            for (int c = 0; c < period; c++) begin
                mic = (c < period / 2) ? high : low;
                @(negedge clk);
            end
        end
    endtask

    // Display may only show the old pattern until it reaches the new one
    task automatic watch_display(input int idx);
        seg_t expected;
        int   cycles;
        expected = hold_note[idx] ? shown_seg : exp_seg[idx];
        cycles   = tone_period[idx] * tone_count[idx];
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (abcdefgh === expected)
                reached = 1'b1;
            else
                check_segments(test_name[idx], reached ? expected : shown_seg, abcdefgh);
        end
        if (!reached)
            report_timeout($sformatf("the display to show %h in %s", expected, test_name[idx]));
    endtask

    task automatic count_to_rise(input string name, input int limit, output int cycles);
        sound_sample_t last;
        logic          rose;
        last   = sound;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
                report_timeout($sformatf("a rising edge of sound in %s", name));
            rose = (last == LEVEL_LOW) && (sound == LEVEL_HIGH);
            last = sound;
        end while (!rose);
    endtask

    task automatic measure_tone(input int idx);
        int half;
        int waited;
        int cycles;
        half   = hold_note[idx] ? shown_half : tone_period[idx] / 2;
        waited = 0;
        while (!reached) begin                        // Tone restarts along with the display
            @(negedge clk);
            waited++;
            if (waited > tone_period[idx] * tone_count[idx])
                report_timeout($sformatf("the new note in %s", test_name[idx]));
        end
        count_to_rise(test_name[idx], 2 * half + 2, cycles);   // Align on a rising edge
        count_to_rise(test_name[idx], 2 * half + 2, cycles);
        check_period(test_name[idx], period_t'(2 * half), period_t'(cycles));
    endtask

    // --------------------
    // Main sequence

    initial begin
        rst     = 1'b1;
        mic     = mic_sample_t'(-1);                  // Negative during reset
        reached = 1'b0;
        build_table();

        repeat (5) @(negedge clk);
        rst = 1'b0;

        check_segments("reset", 8'h9C, abcdefgh);
        check_digit("reset", `W_DIGIT'(1), digit);
        check_sound("reset", LEVEL_LOW, sound);
        shown_seg  = 8'h9C;
        shown_half = 3822 / 2;

        repeat (4) @(negedge clk);

        for (int i = 0; i < n_entries; i++) begin
            reached = 1'b0;
            fork
                play_tone(tone_period[i], tone_count[i]);
                watch_display(i);
                if (tone_check[i])
                    measure_tone(i);
            join
            if (!hold_note[i]) begin
                shown_seg  = exp_seg[i];
                shown_half = tone_period[i] / 2;
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* bench/note_relay_properties.sv */
`timescale 1ns/1ps
`include "note_defines.svh"

module note_relay_properties (
    input                            clk,
    input                            rst,
    input  note_pkg::seg_t           abcdefgh,
    input  logic [`W_DIGIT - 1:0]    digit,
    input  audio_pkg::sound_sample_t sound
);

    import audio_pkg::*;

    localparam sound_sample_t LEVEL_HIGH = sound_sample_t'(`TONE_AMPL);

    // --------------------
    // Output shape

    sound_levels : assert property (@(posedge clk) disable iff (rst)
        (sound == LEVEL_HIGH) || (sound == -LEVEL_HIGH))
        else $error("sound left the two square wave levels");

    digit_select : assert property (@(posedge clk) disable iff (rst)
        digit == `W_DIGIT'(1))
        else $error("digit select is not digit 0 alone");

    // The twelve note patterns C through B
    known_pattern : assert property (@(posedge clk) disable iff (rst)
        abcdefgh inside {8'h9C, 8'h9D, 8'h7A, 8'h7B, 8'h9E, 8'h8E,
                         8'h8F, 8'hBC, 8'hBD, 8'hEE, 8'hEF, 8'h3E})
        else $error("display shows a pattern that is no note");

endmodule

bind note_relay_top note_relay_properties props (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .abcdefgh ( abcdefgh ),
    .digit    ( digit    ),
    .sound    ( sound    )
);

/* src/note_relay_top.sv */
`timescale 1ns/1ps
`include "note_defines.svh"

module note_relay_top (
    input                            clk,
    input                            rst,
    input  audio_pkg::mic_sample_t   mic,
    output note_pkg::seg_t           abcdefgh,
    output logic [`W_DIGIT - 1:0]    digit,
    output audio_pkg::sound_sample_t sound
);

    import note_pkg::*;

    seg_t  seg_pattern;  // Recognized note as a pattern
    note_t note;         // Same note as an index

    // --------------------

    note_recognizer i_note_recognizer (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .mic         ( mic         ),
        .seg_pattern ( seg_pattern )
    );

    // --------------------

    segment_note_decoder i_segment_note_decoder (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .seg_pattern ( seg_pattern ),
        .note        ( note        )
    );

    // --------------------

    note_synthesizer i_note_synthesizer (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .note        ( note        ),
        .abcdefgh    ( abcdefgh    ),
        .digit       ( digit       ),
        .sound       ( sound       )
    );

endmodule

/* src/note_synthesizer.sv */
`timescale 1ns/1ps
`include "note_defines.svh"

module note_synthesizer (
    input                            clk,
    input                            rst,
    input  note_pkg::note_t          note,
    output note_pkg::seg_t           abcdefgh,
    output logic [`W_DIGIT - 1:0]    digit,
    output audio_pkg::sound_sample_t sound
);

    import note_pkg::*;
    import audio_pkg::*;

    localparam sound_sample_t AMPL_POS = sound_sample_t'(`TONE_AMPL);
    localparam sound_sample_t AMPL_NEG = -AMPL_POS;

    // Reload value for a half period of C
    localparam period_t HALF_C = (note_period(note_t'(0)) >> 1) - 1'b1;

    note_t   note_q;       // Note the tone is playing
    logic    note_change;
    period_t half_reload;
    period_t half_cnt;
    logic    tone_high;

    // --------------------
    // Tone generator

    assign note_change = (note != note_q);
    assign half_reload = (note_period(note) >> 1) - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            note_q    <= '0;
            half_cnt  <= HALF_C;
            tone_high <= 1'b0;
        end else if (note_change) begin
            note_q    <= note;
            half_cnt  <= half_reload;                  // Restart on the low phase
            tone_high <= 1'b0;
        end else if (half_cnt == '0) begin
            half_cnt  <= half_reload;
            tone_high <= !tone_high;
        end else begin
            half_cnt  <= half_cnt - 1'b1;
        end
    end

    assign sound = tone_high ? AMPL_POS : AMPL_NEG;

    // --------------------
    // Display

    always_ff @(posedge clk)
        abcdefgh <= note_segments(note);

    assign digit = { {(`W_DIGIT - 1){1'b0}}, 1'b1 };  // Rightmost digit only

endmodule

/* src/segment_note_decoder.sv */
`timescale 1ns/1ps

module segment_note_decoder (
    input                   clk,
    input                   rst,
    input  note_pkg::seg_t  seg_pattern,
    output note_pkg::note_t note
);

    import note_pkg::*;

    logic  known;       // Pattern is one of the twelve notes
    note_t known_note;

    // --------------------
    // Reverse lookup

    always_comb begin
        known      = 1'b0;
        known_note = '0;
        for (int i = 0; i < N_NOTES; i++) begin
            if (seg_pattern == note_segments(note_t'(i))) begin
                known      = 1'b1;
                known_note = note_t'(i);
            end
        end
    end

    // Blank and stray patterns keep the last note
    always_ff @(posedge clk) begin
        if (rst)
            note <= '0;                                // C
        else if (known)
            note <= known_note;
    end

endmodule

/* src/note_recognizer.sv */
`timescale 1ns/1ps
`include "note_defines.svh"

module note_recognizer (
    input                          clk,
    input                          rst,
    input  audio_pkg::mic_sample_t mic,
    output note_pkg::seg_t         seg_pattern
);

    import note_pkg::*;
    import audio_pkg::*;

    localparam int                 W_MATCH    = $clog2(`DEBOUNCE_PERIODS + 1);
    localparam logic [W_MATCH-1:0] MATCH_FULL = W_MATCH'(`DEBOUNCE_PERIODS);

    logic                 prev_neg;    // Sign of the previous sample
    logic                 rising;
    period_t              period_cnt;
    logic                 hit;
    note_t                hit_note;
    logic                 same_note;
    logic [W_MATCH - 1:0] match_cnt;
    logic [W_MATCH - 1:0] match_next;
    note_t                last_note;

    // --------------------
    // Zero crossing and period

    assign rising = prev_neg && !is_negative(mic);

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_neg   <= 1'b0;
            period_cnt <= '0;
        end else begin
            prev_neg <= is_negative(mic);
            if (rising)
                period_cnt <= period_t'(1);            // Crossing cycle starts a new period
            else if (period_cnt != '1)
                period_cnt <= period_cnt + 1'b1;       // Saturates on silence
        end
    end

    // --------------------
    // Classifier

    // At a crossing period_cnt holds the full period just ended
    always_comb begin
        hit      = 1'b0;
        hit_note = '0;
        for (int i = 0; i < N_NOTES; i++) begin
            if (period_cnt >= note_lower_bound(note_t'(i))
                    && period_cnt < note_upper_bound(note_t'(i))) begin
                hit      = 1'b1;
                hit_note = note_t'(i);
            end
        end
    end

    // --------------------
    // Debounce

    assign same_note  = (match_cnt != '0) && (hit_note == last_note);
    assign match_next = !same_note                ? W_MATCH'(1) :
                        (match_cnt == MATCH_FULL) ? MATCH_FULL  :
                                                    match_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            match_cnt   <= '0;
            last_note   <= '0;
            seg_pattern <= seg_blank;
        end else if (rising) begin
            if (!hit) begin
                match_cnt   <= '0;
                seg_pattern <= seg_blank;              // Out of every window
            end else begin
                match_cnt <= match_next;
                last_note <= hit_note;
                if (match_next == MATCH_FULL)
                    seg_pattern <= note_segments(hit_note);
            end
        end
    end

endmodule

/* src/audio_pkg.sv */
`include "note_defines.svh"

package audio_pkg;

    // --------------------
    // Sample types

    typedef logic signed [`W_MIC   - 1:0] mic_sample_t;
    typedef logic signed [`W_SOUND - 1:0] sound_sample_t;

    // --------------------
    // Helpers

    // Only the sign of the microphone is looked at
    function automatic logic is_negative(input mic_sample_t s);
        return s[`W_MIC - 1];
    endfunction

endpackage

/* src/note_pkg.sv */
`include "note_defines.svh"

package note_pkg;

    typedef logic [3:0]             note_t;    // 0 is C, 11 is B
    typedef logic [7:0]             seg_t;     // abcdefgh, h is the dot
    typedef logic [`W_PERIOD - 1:0] period_t;  // Clock cycles

    localparam int   N_NOTES   = 12;
    localparam seg_t seg_blank = 8'b0000_0000;

    // --------------------
    // Display patterns
    // Sharps reuse the natural pattern and light the dot

    function automatic seg_t note_segments(input note_t n);
        case (n)
            4'd0    : return 8'b1001_1100;  // C
            4'd1    : return 8'b1001_1101;  // C#
            4'd2    : return 8'b0111_1010;  // D
            4'd3    : return 8'b0111_1011;  // D#
            4'd4    : return 8'b1001_1110;  // E
            4'd5    : return 8'b1000_1110;  // F
            4'd6    : return 8'b1000_1111;  // F#
            4'd7    : return 8'b1011_1100;  // G
            4'd8    : return 8'b1011_1101;  // G#
            4'd9    : return 8'b1110_1110;  // A
            4'd10   : return 8'b1110_1111;  // A#
            4'd11   : return 8'b0011_1110;  // B
            default : return seg_blank;
        endcase
    endfunction

    // --------------------
    // Octave 4 periods, rounded to the nearest cycle

    function automatic period_t note_period(input note_t n);
        int unsigned freq_chz;  // Centihertz
        case (n)
            4'd1    : freq_chz = 27718;
            4'd2    : freq_chz = 29366;
            4'd3    : freq_chz = 31113;
            4'd4    : freq_chz = 32963;
            4'd5    : freq_chz = 34923;
            4'd6    : freq_chz = 36999;
            4'd7    : freq_chz = 39200;
            4'd8    : freq_chz = 41530;
            4'd9    : freq_chz = 44000;
            4'd10   : freq_chz = 46616;
            4'd11   : freq_chz = 49388;
            default : freq_chz = 26163;  // C and unused codes
        endcase
        return period_t'((`CLK_HZ * 100 + freq_chz / 2) / freq_chz);
    endfunction

    // Windows meet halfway between neighbouring periods
    // Lower bound is inclusive, upper bound exclusive

    function automatic period_t note_lower_bound(input note_t n);
        int unsigned here;
        int unsigned other;
        if (n >= 4'd11) begin
            here  = note_period(4'd11);
            other = note_period(4'd10);
            return period_t'(2 * here - (here + other) / 2);  // Mirror of the upper side
        end
        here  = note_period(n);
        other = note_period(n + 1'b1);
        return period_t'((here + other) / 2);
    endfunction

    function automatic period_t note_upper_bound(input note_t n);
        int unsigned here;
        int unsigned other;
        if (n == 4'd0) begin
            here  = note_period(4'd0);
            other = note_period(4'd1);
            return period_t'(2 * here - (here + other) / 2);  // Mirror of the lower side
        end
        here  = note_period(n);
        other = note_period(n - 1'b1);
        return period_t'((here + other) / 2);
    endfunction

endpackage

/* src/note_defines.svh */
`ifndef NOTE_DEFINES_SVH
`define NOTE_DEFINES_SVH

// --------------------
// Clock and sample widths

// Design clock rate in Hz
`define CLK_HZ            1000000

`define W_MIC             24
`define W_SOUND           16

// One select line per display digit
`define W_DIGIT           8

// --------------------
// Tone and recognition

// Magnitude of the square wave on the sound output
`define TONE_AMPL         8192

// Matching periods in a row before a note is shown
`define DEBOUNCE_PERIODS  2

// Wide enough for periods well below 20 Hz at CLK_HZ
`define W_PERIOD          16

`endif
